//--- design/shell_pkg.sv
// shared widths, region map and bus structs for the board shell; region sizes are fixed

package shell_pkg;

	// ========================================
	// widths that carry a meaning
	// ========================================
	typedef logic [15:0] store_addr_t; // byte address into the store
	typedef logic [7:0]  rom_byte_t;
	typedef logic [13:0] prg_addr_t;   // 16 KB program region
	typedef logic [14:0] bank_addr_t;  // 32 KB banked region
	typedef logic [12:0] snd_addr_t;   // 8 KB sound region
	typedef logic [3:0]  color_t;      // color or intensity channel
	typedef logic [7:0]  sample_t;

	// ========================================
	// store map
	// ========================================
	localparam store_addr_t prg_base  = 16'h0000;
	localparam store_addr_t bank_base = 16'h4000;
	localparam store_addr_t snd_base  = 16'hC000;
	localparam int store_depth = 'hE000; // sound region ends at 0xDFFF
	localparam rom_byte_t rom_fill_byte = 8'hFF; // fetch data while downloading

	// ========================================
	// buses
	// ========================================
	// host download stream, plain strobe and level
	typedef struct packed {
		logic        active; // high for the whole download
		logic        wr;     // byte strobe, rising edge counts
		logic [7:0]  index;  // only index 0 goes to the store
		store_addr_t addr;
		rom_byte_t   data;
	} dl_bus_t;

	typedef struct packed {
		logic        en; // one cycle per byte
		store_addr_t addr;
		rom_byte_t   data;
	} store_wr_t;

	// pixel as the game core produces it
	typedef struct packed {
		color_t r;
		color_t g;
		color_t b;
		color_t i;      // intensity
		logic   blankn;
		logic   hs;
		logic   vs;
	} game_pixel_t;

	typedef struct packed {
		color_t r;
		color_t g;
		color_t b;
		logic   hs;
		logic   vs;
	} vga_pixel_t;

endpackage

//--- design/rom_loader.sv
// download strobe and data must be synchronous to clk_sys; only index 0 bytes are stored

`timescale 1ns/100ps

module rom_loader (
	input  logic                clk_sys,
	input  logic                reset,
	input  shell_pkg::dl_bus_t  dl_bus,
	input  logic                menu_reset,
	output shell_pkg::store_wr_t store_wr,
	output logic                loading,
	output logic                rom_loaded,
	output logic                core_reset
);

	logic wr_last; // strobe as seen on the previous edge
	logic wr_take; // qualifying rising strobe this cycle
	logic wr_en;
	shell_pkg::store_addr_t wr_addr;
	shell_pkg::rom_byte_t   wr_data;

	assign wr_take = dl_bus.wr & ~wr_last & dl_bus.active & (dl_bus.index == 8'd0);

	// ========================================
	// control state
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wr_last    <= 1'b0;
			wr_en      <= 1'b0;
			loading    <= 1'b0;
			rom_loaded <= 1'b0;
			core_reset <= 1'b1; // game held until a download ends
		end else begin
			wr_last <= dl_bus.wr;
			wr_en   <= wr_take; // one cycle pulse
			loading <= dl_bus.active; // also the previous active level

			// falling edge of active ends the download
			if (loading & ~dl_bus.active)
				rom_loaded <= 1'b1;

			core_reset <= menu_reset | ~rom_loaded;
		end
	end

	// ========================================
	// write payload
	// ========================================
	// byte and address captured with the strobe edge
	always_ff @(posedge clk_sys) begin
		if (wr_take) begin
			wr_addr <= dl_bus.addr;
			wr_data <= dl_bus.data;
		end
	end

	assign store_wr = '{en: wr_en, addr: wr_addr, data: wr_data};

endmodule

//--- design/rom_store.sv
// on-chip stand-in for the game ROM; writes beyond store_depth are dropped, memory powers up unknown

`timescale 1ns/100ps

module rom_store (
	input  logic                   clk_sys,
	input  shell_pkg::store_wr_t   store_wr,
	input  logic                   loading,
	input  shell_pkg::prg_addr_t   prg_addr,
	output shell_pkg::rom_byte_t   prg_data,
	input  shell_pkg::bank_addr_t  bank_addr,
	output shell_pkg::rom_byte_t   bank_data,
	input  shell_pkg::snd_addr_t   snd_addr,
	output shell_pkg::rom_byte_t   snd_data
);

	shell_pkg::rom_byte_t mem [0:shell_pkg::store_depth-1];

	shell_pkg::store_addr_t prg_full;  // store address of each port
	shell_pkg::store_addr_t bank_full;
	shell_pkg::store_addr_t snd_full;
	logic                   wr_in_range;

	// ========================================
	// region mapping
	// ========================================
	// each port is offset into its own slice of the store
	assign prg_full  = shell_pkg::prg_base  + shell_pkg::store_addr_t'(prg_addr);
	assign bank_full = shell_pkg::bank_base + shell_pkg::store_addr_t'(bank_addr);
	assign snd_full  = shell_pkg::snd_base  + shell_pkg::store_addr_t'(snd_addr);

	assign wr_in_range = int'(store_wr.addr) < shell_pkg::store_depth;

	// ========================================
	// write port
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (store_wr.en && wr_in_range)
			mem[store_wr.addr] <= store_wr.data;
	end

	// ========================================
	// read ports
	// ========================================
	// all three read every cycle, one cycle latency
	always_ff @(posedge clk_sys) begin
		if (loading) begin
			// fetches are parked while the host writes
			prg_data  <= shell_pkg::rom_fill_byte;
			bank_data <= shell_pkg::rom_fill_byte;
			snd_data  <= shell_pkg::rom_fill_byte;
		end else begin
			prg_data  <= mem[prg_full];
			bank_data <= mem[bank_full];
			snd_data  <= mem[snd_full];
		end
	end

endmodule

//--- design/video_mixer.sv
// one pixel per clk_sys; intensity scaling keeps only the top four bits of the product

`timescale 1ns/100ps

module video_mixer (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  shell_pkg::game_pixel_t pix_in,
	output shell_pkg::vga_pixel_t  pix_out
);

	logic [7:0] r_scaled; // channel times intensity
	logic [7:0] g_scaled;
	logic [7:0] b_scaled;
	shell_pkg::vga_pixel_t pix_next;

	// ========================================
	// intensity and blanking
	// ========================================
	assign r_scaled = pix_in.r * pix_in.i;
	assign g_scaled = pix_in.g * pix_in.i;
	assign b_scaled = pix_in.b * pix_in.i;

	always_comb begin
		pix_next.hs = pix_in.hs;
		pix_next.vs = pix_in.vs;
		if (pix_in.blankn) begin
			pix_next.r = r_scaled[7:4];
			pix_next.g = g_scaled[7:4];
			pix_next.b = b_scaled[7:4];
		end else begin
			pix_next.r = '0; // black outside the active area
			pix_next.g = '0;
			pix_next.b = '0;
		end
	end

	// ========================================
	// output register
	// ========================================
	// color and syncs share one stage so they stay aligned
	always_ff @(posedge clk_sys) begin
		if (reset)
			pix_out <= '0;
		else
			pix_out <= pix_next;
	end

endmodule

//--- design/audio_dac.sv
// first-order delta-sigma at clk_sys rate; needs an external RC low-pass on audio_out

`timescale 1ns/100ps

module audio_dac (
	input  logic               clk_sys,
	input  logic               reset,
	input  shell_pkg::sample_t sample,
	output logic               audio_out
);

	logic [7:0] acc;     // running error, low bits only
	logic [8:0] acc_sum; // bit 8 is the carry

	assign acc_sum = {1'b0, acc} + {1'b0, sample};

	// ========================================
	// modulator
	// ========================================
	// density of ones follows sample / 256
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			acc       <= '0;
			audio_out <= 1'b0;
		end else begin
			acc       <= acc_sum[7:0];
			audio_out <= acc_sum[8]; // carry out is the pulse
		end
	end

endmodule

//--- design/board_shell.sv
// board shell around the game core; single clock, ROM held on chip, no SPI link or OSD

`timescale 1ns/100ps

module board_shell (
	input  logic                   clk_sys,
	input  logic                   reset,

	// host download stream
	input  shell_pkg::dl_bus_t     dl_bus,
	input  logic                   menu_reset,

	// game ROM fetch ports
	input  shell_pkg::prg_addr_t   prg_addr,
	input  shell_pkg::bank_addr_t  bank_addr,
	input  shell_pkg::snd_addr_t   snd_addr,
	output shell_pkg::rom_byte_t   prg_data,
	output shell_pkg::rom_byte_t   bank_data,
	output shell_pkg::rom_byte_t   snd_data,

	// video
	input  shell_pkg::game_pixel_t game_pix,
	output shell_pkg::vga_pixel_t  vga_pix,

	// audio
	input  shell_pkg::sample_t     sample,
	output logic                   audio_out,

	// game control
	output logic                   rom_loaded,
	output logic                   core_reset
);

	shell_pkg::store_wr_t store_wr; // loader to store
	logic                 loading;  // download in progress, registered

	// ========================================
	// ROM download and game reset
	// ========================================
	rom_loader u_rom_loader (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.dl_bus     (dl_bus),
		.menu_reset (menu_reset),
		.store_wr   (store_wr),
		.loading    (loading),
		.rom_loaded (rom_loaded),
		.core_reset (core_reset)
	);

	// ========================================
	// ROM store
	// ========================================
	rom_store u_rom_store (
		.clk_sys   (clk_sys),
		.store_wr  (store_wr),
		.loading   (loading),
		.prg_addr  (prg_addr),
		.prg_data  (prg_data),
		.bank_addr (bank_addr),
		.bank_data (bank_data),
		.snd_addr  (snd_addr),
		.snd_data  (snd_data)
	);

	// ========================================
	// video out
	// ========================================
	video_mixer u_video_mixer (
		.clk_sys (clk_sys),
		.reset   (reset),
		.pix_in  (game_pix),
		.pix_out (vga_pix)
	);

	// ========================================
	// audio out
	// ========================================
	// one-bit stream, same pin for both channels on the board
	audio_dac u_audio_dac (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.sample    (sample),
		.audio_out (audio_out)
	);

endmodule

//--- bench/tb_board_shell.sv
// drives every input on the falling edge; the full ROM download takes about 5 ms of sim time

`timescale 1ns/100ps

module tb_board_shell;

	logic                   clk_sys;
	logic                   reset;
	shell_pkg::dl_bus_t     dl_bus;
	logic                   menu_reset;
	shell_pkg::prg_addr_t   prg_addr;
	shell_pkg::bank_addr_t  bank_addr;
	shell_pkg::snd_addr_t   snd_addr;
	shell_pkg::rom_byte_t   prg_data;
	shell_pkg::rom_byte_t   bank_data;
	shell_pkg::rom_byte_t   snd_data;
	shell_pkg::game_pixel_t game_pix;
	shell_pkg::vga_pixel_t  vga_pix;
	shell_pkg::sample_t     sample;
	logic                   audio_out;
	logic                   rom_loaded;
	logic                   core_reset;

	shell_pkg::rom_byte_t model [0:shell_pkg::store_depth-1]; // every byte sent with index 0

	logic [15:0] lfsr_state = 16'd16;
	logic        addr_scramble = 1'b0; // new fetch addresses each cycle
	logic        fetch_check = 1'b0;
	logic        fetch_armed = 1'b0;
	logic        pix_armed = 1'b0;
	shell_pkg::rom_byte_t  exp_prg;
	shell_pkg::rom_byte_t  exp_bank;
	shell_pkg::rom_byte_t  exp_snd;
	shell_pkg::vga_pixel_t exp_pix;

	int errors = 0;
	int timeouts = 0;
	int fetch_checks = 0;
	int pixel_checks = 0;

	board_shell DUT (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.dl_bus     (dl_bus),
		.menu_reset (menu_reset),
		.prg_addr   (prg_addr),
		.bank_addr  (bank_addr),
		.snd_addr   (snd_addr),
		.prg_data   (prg_data),
		.bank_data  (bank_data),
		.snd_data   (snd_data),
		.game_pix   (game_pix),
		.vga_pix    (vga_pix),
		.sample     (sample),
		.audio_out  (audio_out),
		.rom_loaded (rom_loaded),
		.core_reset (core_reset)
	);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	// ========================================
	// helpers
	// ========================================
	task automatic report_err(input string msg);
		errors++;
		$display("ERR %0t: %s", $time, msg);
	endtask

	// galois lfsr with taps 16 14 13 11 and one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < n; k++) begin
			if (lfsr_state[0])
				lfsr_state = (lfsr_state >> 1) ^ 16'hB400;
			else
				lfsr_state = lfsr_state >> 1;
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	// top nibble of channel times intensity
	function automatic shell_pkg::vga_pixel_t expected_pixel(input shell_pkg::game_pixel_t p);
		shell_pkg::vga_pixel_t v;
		int pr;
		int pg;
		int pb;
		pr = int'(p.r) * int'(p.i);
		pg = int'(p.g) * int'(p.i);
		pb = int'(p.b) * int'(p.i);
		v.hs = p.hs;
		v.vs = p.vs;
		v.r = p.blankn ? shell_pkg::color_t'(pr / 16) : 4'd0;
		v.g = p.blankn ? shell_pkg::color_t'(pg / 16) : 4'd0;
		v.b = p.blankn ? shell_pkg::color_t'(pb / 16) : 4'd0;
		return v;
	endfunction

	task automatic next_cycle();
		@(negedge clk_sys);
		if (addr_scramble) begin
			prg_addr  = shell_pkg::prg_addr_t'(rand_bits(14));
			bank_addr = shell_pkg::bank_addr_t'(rand_bits(15));
			snd_addr  = shell_pkg::snd_addr_t'(rand_bits(13));
		end
	endtask

	// sel 0 picks rom_loaded and sel 1 picks core_reset
	task automatic wait_flag(input int sel, input logic level, input int limit);
		int n;
		logic seen;
		n = 0;
		seen = (sel == 0) ? rom_loaded : core_reset;
		while (seen !== level && n < limit) begin
			next_cycle();
			n++;
			seen = (sel == 0) ? rom_loaded : core_reset;
		end
		if (seen !== level) begin
			timeouts++;
			errors++;
			$display("timeout at %0t: %s never reached %b within %0d cycles", $time,
				(sel == 0) ? "rom_loaded" : "core_reset", level, limit);
		end
	endtask

	// one strobe then 0 to 3 idle cycles so rises are 2 to 5 cycles apart
	task automatic send_strobe(input logic [7:0] idx, input int a, input shell_pkg::rom_byte_t d);
		int gap;
		next_cycle();
		dl_bus.index = idx;
		dl_bus.addr  = shell_pkg::store_addr_t'(a);
		dl_bus.data  = d;
		dl_bus.wr    = 1'b1;
		next_cycle();
		dl_bus.wr = 1'b0;
		gap = int'(rand_bits(2));
		repeat (gap) next_cycle();
	endtask

	// ========================================
	// reference for the registered outputs
	// ========================================
	always @(posedge clk_sys) begin
		fetch_armed <= fetch_check;
		exp_prg  <= model[int'(shell_pkg::prg_base) + int'(prg_addr)];
		exp_bank <= model[int'(shell_pkg::bank_base) + int'(bank_addr)];
		exp_snd  <= model[int'(shell_pkg::snd_base) + int'(snd_addr)];
		exp_pix  <= reset ? '0 : expected_pixel(game_pix);
		pix_armed <= 1'b1;
	end

	always @(posedge clk_sys) begin
		if (fetch_armed) begin
			fetch_checks++;
			assert (prg_data === exp_prg)
				else report_err($sformatf("prg_data %h, expected %h", prg_data, exp_prg));
			assert (bank_data === exp_bank)
				else report_err($sformatf("bank_data %h, expected %h", bank_data, exp_bank));
			assert (snd_data === exp_snd)
				else report_err($sformatf("snd_data %h, expected %h", snd_data, exp_snd));
		end
		if (pix_armed) begin
			pixel_checks++;
			assert (vga_pix === exp_pix)
				else report_err($sformatf("vga_pix %h, expected %h", vga_pix, exp_pix));
		end
	end

	// ========================================
	// timing rules
	// ========================================
	fill_while_loading: assert property (@(posedge clk_sys) disable iff (reset)
		$past(dl_bus.active, 2) |-> (prg_data == 8'hFF && bank_data == 8'hFF
			&& snd_data == 8'hFF))
		else report_err("fetch data is not 0xFF while a download is active");

	core_reset_rule: assert property (@(posedge clk_sys) disable iff (reset)
		!$past(reset) |-> core_reset == ($past(menu_reset) || !$past(rom_loaded)))
		else report_err("core_reset does not follow menu_reset and rom_loaded");

	loaded_rule: assert property (@(posedge clk_sys) disable iff (reset)
		!$past(reset) |-> rom_loaded == ($past(rom_loaded)
			|| ($past(dl_bus.active, 2) && !$past(dl_bus.active))))
		else report_err("rom_loaded does not rise one cycle after active falls");

	after_reset: assert property (@(posedge clk_sys) disable iff (reset)
		$past(reset) |-> (core_reset && !rom_loaded))
		else report_err("control outputs not in reset state after reset");

	// ========================================
	// stimulus
	// ========================================
	task automatic download_rom();
		int a;
		int victim;
		shell_pkg::rom_byte_t d;
		addr_scramble = 1'b1;
		next_cycle();
		dl_bus.active = 1'b1;
		for (a = 0; a < shell_pkg::store_depth; a++) begin
			d = shell_pkg::rom_byte_t'(rand_bits(8));
			model[a] = d;
			send_strobe(8'd0, a, d);
			// index 1 strobe aimed at a byte already written
			if (a > 0 && rand_bits(3) == 0) begin
				victim = int'(rand_bits(16)) % a;
				send_strobe(8'd1, victim, ~model[victim]);
			end
		end
		next_cycle();
		dl_bus.active = 1'b0;
		wait_flag(0, 1'b1, 4);
		wait_flag(1, 1'b0, 4);
	endtask

	task automatic check_fetch();
		addr_scramble = 1'b0;
		fetch_check = 1'b1;
		// walk every region once and wrap the smaller ones
		for (int k = 0; k < 32768; k++) begin
			next_cycle();
			prg_addr  = shell_pkg::prg_addr_t'(k);
			bank_addr = shell_pkg::bank_addr_t'(k);
			snd_addr  = shell_pkg::snd_addr_t'(k);
		end
		addr_scramble = 1'b1; // back to back random reads
		repeat (2000) next_cycle();
		addr_scramble = 1'b0;
		fetch_check = 1'b0;
		next_cycle();
	endtask

	task automatic check_video();
		logic [31:0] r;
		repeat (600) begin
			next_cycle();
			r = rand_bits(19);
			game_pix = r[18:0];
		end
		next_cycle();
		game_pix = '0;
	endtask

	task automatic check_audio();
		int levels [8];
		int ones;
		levels = '{0, 128, 255, 1, 64, 200, 0, 0};
		levels[6] = int'(rand_bits(8));
		levels[7] = int'(rand_bits(8));
		foreach (levels[n]) begin
			next_cycle();
			sample = shell_pkg::sample_t'(levels[n]);
			repeat (2) next_cycle(); // let the new level reach the output
			ones = 0;
			repeat (256) begin
				next_cycle();
				ones += int'(audio_out);
			end
			assert (ones == levels[n] || ones == levels[n] + 1)
				else report_err($sformatf("sample %0d gave %0d ones in 256", levels[n], ones));
		end
		sample = '0;
	endtask

	task automatic check_reset_sources();
		next_cycle();
		menu_reset = 1'b1;
		wait_flag(1, 1'b1, 3);
		repeat (5) begin
			next_cycle();
			assert (core_reset === 1'b1) else report_err("core_reset dropped under menu_reset");
		end
		menu_reset = 1'b0;
		wait_flag(1, 1'b0, 3);
		// board reset forgets the download
		next_cycle();
		reset = 1'b1;
		repeat (3) next_cycle();
		assert (rom_loaded === 1'b0 && core_reset === 1'b1)
			else report_err("board reset did not clear rom_loaded");
		reset = 1'b0;
		repeat (10) next_cycle();
		assert (rom_loaded === 1'b0) else report_err("rom_loaded came back without a download");
	endtask

	// ========================================
	// main sequence
	// ========================================
	initial begin
		reset      = 1'b1;
		dl_bus     = '0;
		menu_reset = 1'b0;
		prg_addr   = '0;
		bank_addr  = '0;
		snd_addr   = '0;
		game_pix   = '0;
		sample     = '0;

		repeat (10) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;

		// game stays held with nothing loaded
		repeat (20) begin
			next_cycle();
			assert (core_reset === 1'b1 && rom_loaded === 1'b0)
				else report_err("control outputs left reset state before a download");
		end

		download_rom();
		check_fetch();
		check_video();
		check_audio();
		check_reset_sources();

		$display("closing: errors=%0d timeouts=%0d fetch_checks=%0d pixel_checks=%0d",
			errors, timeouts, fetch_checks, pixel_checks);
		if (errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

//--- build.f
design/shell_pkg.sv
design/rom_loader.sv
design/rom_store.sv
design/video_mixer.sv
design/audio_dac.sv
design/board_shell.sv
bench/tb_board_shell.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the board shell testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_board_shell
OBJ=obj_dir
LOG=sim.log

verilator --binary --timing --assert --top-module "$TOP" -Mdir "$OBJ" -f build.f
if [ $? -ne 0 ]; then
	echo "verilator compile step failed"
	exit 1
fi

"./$OBJ/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "TB FAILED" "$LOG"; then
	echo "simulation log reports a failure"
	exit 1
fi

echo "simulation log is clean"
exit 0
